/* logic/rv_pkg.sv */
// ####################
// rv64i core package
// ####################
`default_nettype none

package rv_pkg;

  // datapath widths
  localparam int xlen         = 64;
  localparam int inst_width   = 32;
  localparam int reg_id_width = 5;

  // first fetch address
  localparam logic [xlen-1:0] pc_reset = 64'h0000_0000_8000_0000;

  // data memory geometry, in doublewords
  localparam int dmem_depth      = 32;
  localparam int dmem_addr_width = 5;

  // major opcodes
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_system = 7'b1110011;

  // alu selector
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    // operand b straight through, for lui
    alu_pass_b
  } alu_op_t;

  // decoder output bundle
  typedef struct packed {
    logic [reg_id_width-1:0] rd;
    logic [reg_id_width-1:0] rs1;
    logic [reg_id_width-1:0] rs2;
    logic [xlen-1:0]         imm;
    alu_op_t                 alu_op;
    logic                    need_imm;
    logic                    is_auipc;
    logic                    is_jal;
    logic                    is_jalr;
    logic                    is_load;
    logic                    reg_wen;
    logic                    mem_wen;
    logic                    is_ebreak;
    logic                    illegal;
  } decode_t;

  // one retired instruction
  typedef struct packed {
    logic                    valid;
    logic [xlen-1:0]         pc;
    logic [reg_id_width-1:0] rd;
    logic [xlen-1:0]         wdata;
    logic                    wen;
  } retire_t;

endpackage

`default_nettype wire

/* logic/rv_decoder.sv */
// ####################
// rv64i decoder
// ####################
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  wire logic [inst_width-1:0] inst,
  output decode_t                    dec
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [5:0]      funct6;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  // rv64 shifts carry a 6 bit shamt, so only funct6 is fixed
  assign funct6 = inst[31:26];

  // immediate formats, all sign extended from bit 31
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec        = '0;
    dec.rd     = inst[11:7];
    dec.rs1    = inst[19:15];
    dec.rs2    = inst[24:20];
    dec.alu_op = alu_add;
    case (opcode)
      op_imm: begin
        dec.imm      = imm_i;
        dec.need_imm = 1'b1;
        dec.reg_wen  = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = alu_add;
          3'b111: dec.alu_op = alu_and;
          3'b110: dec.alu_op = alu_or;
          3'b100: dec.alu_op = alu_xor;
          3'b001: begin
            dec.alu_op  = alu_sll;
            dec.illegal = (funct6 != 6'd0);
          end
          3'b101: begin
            // srai has funct6 010000, not supported
            dec.alu_op  = alu_srl;
            dec.illegal = (funct6 != 6'd0);
          end
          default: dec.illegal = 1'b1;
        endcase
      end
      op_reg: begin
        dec.reg_wen = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec.alu_op = alu_add;
          {7'h20, 3'b000}: dec.alu_op = alu_sub;
          {7'h00, 3'b111}: dec.alu_op = alu_and;
          {7'h00, 3'b110}: dec.alu_op = alu_or;
          {7'h00, 3'b100}: dec.alu_op = alu_xor;
          {7'h00, 3'b001}: dec.alu_op = alu_sll;
          {7'h00, 3'b101}: dec.alu_op = alu_srl;
          default:         dec.illegal = 1'b1;
        endcase
      end
      op_lui: begin
        dec.imm      = imm_u;
        dec.need_imm = 1'b1;
        dec.alu_op   = alu_pass_b;
        dec.reg_wen  = 1'b1;
      end
      op_auipc: begin
        dec.imm      = imm_u;
        dec.need_imm = 1'b1;
        dec.is_auipc = 1'b1;
        dec.reg_wen  = 1'b1;
      end
      op_jal: begin
        // target is pc + imm_j, core feeds pc into operand a
        dec.imm      = imm_j;
        dec.need_imm = 1'b1;
        dec.is_jal   = 1'b1;
        dec.reg_wen  = 1'b1;
      end
      op_jalr: begin
        dec.imm      = imm_i;
        dec.need_imm = 1'b1;
        dec.is_jalr  = (funct3 == 3'b000);
        dec.illegal  = (funct3 != 3'b000);
        dec.reg_wen  = 1'b1;
      end
      op_load: begin
        // ld only
        dec.imm      = imm_i;
        dec.need_imm = 1'b1;
        dec.is_load  = (funct3 == 3'b011);
        dec.illegal  = (funct3 != 3'b011);
        dec.reg_wen  = 1'b1;
      end
      op_store: begin
        // sd only
        dec.imm      = imm_s;
        dec.need_imm = 1'b1;
        dec.illegal  = (funct3 != 3'b011);
        dec.mem_wen  = 1'b1;
      end
      op_system: begin
        // ebreak is the single legal system encoding
        dec.is_ebreak = (inst == 32'h0010_0073);
        dec.illegal   = (inst != 32'h0010_0073);
      end
      default: dec.illegal = 1'b1;
    endcase
    // unsupported encodings must not touch state
    if (dec.illegal) begin
      dec.reg_wen = 1'b0;
      dec.mem_wen = 1'b0;
    end
  end

  // a decoded op is either a write-back or a store, never both
  always_comb begin
    if (!$isunknown(inst)) begin
      assert (!(dec.reg_wen && dec.mem_wen))
        else $error("decoder: reg_wen and mem_wen both set");
    end
  end

endmodule

`default_nettype wire

/* logic/rv_alu.sv */
// ####################
// rv64i alu
// ####################
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  wire logic [xlen-1:0] operand_a,
  input  wire logic [xlen-1:0] operand_b,
  input  wire alu_op_t         alu_op,
  output logic [xlen-1:0]      result
);

  // rv64 shift amount is six bits
  logic [5:0] shamt;

  assign shamt = operand_b[5:0];

  always_comb begin
    case (alu_op)
      alu_add: result = operand_a + operand_b;
      alu_sub: result = operand_a - operand_b;
      alu_and: result = operand_a & operand_b;
      alu_or:  result = operand_a | operand_b;
      alu_xor: result = operand_a ^ operand_b;
      // logical shifts only
      alu_sll: result = operand_a << shamt;
      alu_srl: result = operand_a >> shamt;
      // lui value
      alu_pass_b: result = operand_b;
      default: result = operand_a + operand_b;
    endcase
  end

endmodule

`default_nettype wire

/* logic/rv_regfile.sv */
// ####################
// rv64i register file
// ####################
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic [reg_id_width-1:0] rs1,
  input  wire logic [reg_id_width-1:0] rs2,
  output logic [xlen-1:0]              rdata_1,
  output logic [xlen-1:0]              rdata_2,
  input  wire logic [reg_id_width-1:0] rd,
  input  wire logic [xlen-1:0]         wdata,
  input  wire logic                    wen
);

  // x1..x31, x0 has no storage
  logic [xlen-1:0] regs [1:2**reg_id_width-1];

  // read ports, x0 reads as zero
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 2**reg_id_width; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      // writes to x0 dropped
      regs[rd] <= wdata;
    end
  end

  // x0 stays hard zero on both ports
  a_x0_rs1: assert property (@(posedge clk) disable iff (!rst_n)
    (rs1 == '0) |-> (rdata_1 == '0))
    else $error("regfile: x0 read on port 1 not zero");

  a_x0_rs2: assert property (@(posedge clk) disable iff (!rst_n)
    (rs2 == '0) |-> (rdata_2 == '0))
    else $error("regfile: x0 read on port 2 not zero");

endmodule

`default_nettype wire

/* logic/rv_data_mem.sv */
// ####################
// rv64i data memory
// ####################
`timescale 1ns/1ps
`default_nettype none

module rv_data_mem import rv_pkg::*; (
  input  wire logic            clk,
  input  wire logic [xlen-1:0] addr,
  input  wire logic [xlen-1:0] wdata,
  input  wire logic            wen,
  output logic [xlen-1:0]      rdata
);

  // doubleword array, contents undefined until stored
  logic [xlen-1:0] mem [dmem_depth];

  // doubleword index from byte address
  logic [dmem_addr_width-1:0] index;

  assign index = addr[dmem_addr_width+2:3];

  // combinational read for ld
  assign rdata = mem[index];

  // sd lands at the edge
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[index] <= wdata;
    end
  end

  // only whole aligned doublewords are stored
  a_store_aligned: assert property (@(posedge clk)
    wen |-> (addr[2:0] == 3'b000))
    else $error("data_mem: misaligned sd to %h", addr);

endmodule

`default_nettype wire

/* logic/rv_pc_unit.sv */
// ####################
// rv64i pc unit
// ####################
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit import rv_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            accept,
  input  wire decode_t         dec,
  input  wire logic [xlen-1:0] alu_result,
  output logic [xlen-1:0]      pc,
  output logic [xlen-1:0]      pc_plus4,
  output logic                 halted
);

  logic [xlen-1:0] next_pc;

  // sequential successor, also the jal/jalr link value
  assign pc_plus4 = pc + 64'd4;

  // jump target from alu, bit 0 cleared for both jal and jalr
  assign next_pc = (dec.is_jal || dec.is_jalr) ?
                   {alu_result[xlen-1:1], 1'b0} : pc_plus4;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= pc_reset;
      halted <= 1'b0;
    end else if (accept) begin
      pc <= next_pc;
      // ebreak freezes the core until reset
      if (dec.is_ebreak) begin
        halted <= 1'b1;
      end
    end
  end

  // pc frozen once halted
  a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> $stable(pc))
    else $error("pc_unit: pc moved while halted");

endmodule

`default_nettype wire

/* logic/rv_core.sv */
// ####################
// rv64i single cycle core
// ####################
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  inst_valid,
  input  wire logic [inst_width-1:0] inst,
  output logic [xlen-1:0]            pc,
  output retire_t                    retire,
  output logic                       halted,
  output logic                       illegal
);

  decode_t         dec;
  logic            accept;
  logic            rf_wen;
  logic            mem_wen;
  logic [xlen-1:0] rdata_1;
  logic [xlen-1:0] rdata_2;
  logic [xlen-1:0] operand_a;
  logic [xlen-1:0] operand_b;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] mem_rdata;
  logic [xlen-1:0] wb_data;
  logic [xlen-1:0] pc_plus4;

  // strobes after ebreak are dropped
  assign accept = inst_valid && !halted;

  assign illegal = inst_valid && dec.illegal;

  rv_decoder u_decoder (
    .inst (inst),
    .dec  (dec)
  );

  // write enables only for accepted instructions
  assign rf_wen  = accept && dec.reg_wen;
  assign mem_wen = accept && dec.mem_wen;

  rv_regfile u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2),
    .rd      (dec.rd),
    .wdata   (wb_data),
    .wen     (rf_wen)
  );

  // operand a is pc for auipc and for jal targets
  assign operand_a = (dec.is_auipc || dec.is_jal) ? pc : rdata_1;
  assign operand_b = dec.need_imm ? dec.imm : rdata_2;

  rv_alu u_alu (
    .operand_a (operand_a),
    .operand_b (operand_b),
    .alu_op    (dec.alu_op),
    .result    (alu_result)
  );

  // ld/sd address straight from alu
  rv_data_mem u_data_mem (
    .clk   (clk),
    .addr  (alu_result),
    .wdata (rdata_2),
    .wen   (mem_wen),
    .rdata (mem_rdata)
  );

  rv_pc_unit u_pc_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .accept     (accept),
    .dec        (dec),
    .alu_result (alu_result),
    .pc         (pc),
    .pc_plus4   (pc_plus4),
    .halted     (halted)
  );

  // write-back select: link, load data, or alu
  always_comb begin
    if (dec.is_jal || dec.is_jalr) begin
      wb_data = pc_plus4;
    end else if (dec.is_load) begin
      wb_data = mem_rdata;
    end else begin
      wb_data = alu_result;
    end
  end

  // retire record, same cycle as the strobe
  always_comb begin
    retire.valid = accept;
    retire.pc    = pc;
    retire.rd    = dec.rd;
    retire.wdata = wb_data;
    // x0 writes are not real writes
    retire.wen   = rf_wen && (dec.rd != '0);
  end

  // nothing retires once halted
  a_no_retire_halted: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !retire.valid)
    else $error("core: retire while halted");

endmodule

`default_nettype wire

/* tests/rv_core_tb.sv */
// ####################
// rv64i core testbench
// ####################
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

  // one table row: stimulus plus expected outputs
  typedef struct packed {
    logic [inst_width-1:0]   word;
    logic                    strobe;
    logic [xlen-1:0]         exp_pc;
    logic                    exp_valid;
    logic                    exp_wen;
    logic [reg_id_width-1:0] exp_rd;
    logic [xlen-1:0]         exp_wdata;
    logic                    exp_halted;
    logic                    exp_illegal;
  } step_t;

  logic                  clk;
  logic                  rst_n;
  logic                  inst_valid;
  logic [inst_width-1:0] inst;
  logic [xlen-1:0]       pc;
  retire_t               retire;
  logic                  halted;
  logic                  illegal;

  step_t           steps[$];
  logic [xlen-1:0] model_pc;
  logic            model_halted;
  logic            table_ready;
  int              checks;
  int              errors;

  rv_core dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .retire     (retire),
    .halted     (halted),
    .illegal    (illegal)
  );

  // 4 ns period
  initial clk = 1'b0;
  always #2 clk = ~clk;

  // instruction encoders, straight from the rv64i formats
  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    // sd only, funct3 011
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // 0 to 2 idle cycles, pc and halted carried over
  task automatic idle_gap();
    step_t       s;
    int unsigned n;
    n = $urandom % 3;
    for (int unsigned k = 0; k < n; k++) begin
      s            = '0;
      s.exp_pc     = model_pc;
      s.exp_halted = model_halted;
      steps.push_back(s);
    end
  endtask

  // strobed row; a halted core retires nothing and keeps pc
  task automatic queue_strobe(logic [31:0] word, logic wen, logic [4:0] rd,
                              logic [xlen-1:0] wdata, logic [xlen-1:0] next_pc,
                              logic ill, logic brk);
    step_t s;
    s             = '0;
    s.word        = word;
    s.strobe      = 1'b1;
    s.exp_pc      = model_pc;
    s.exp_valid   = !model_halted;
    s.exp_wen     = wen && !model_halted;
    s.exp_rd      = rd;
    s.exp_wdata   = wdata;
    s.exp_halted  = model_halted;
    s.exp_illegal = ill;
    steps.push_back(s);
    if (!model_halted) begin
      model_pc = next_pc;
      if (brk) begin
        model_halted = 1'b1;
      end
    end
    idle_gap();
  endtask

  // plain register write, sequential pc
  task automatic write_op(logic [31:0] word, logic [4:0] rd, logic [xlen-1:0] wdata);
    queue_strobe(word, 1'b1, rd, wdata, model_pc + 64'd4, 1'b0, 1'b0);
  endtask

  task automatic build_program();
    logic [xlen-1:0] base;
    model_pc     = pc_reset;
    model_halted = 1'b0;
    // x1 = 5, x2 = -3
    write_op(i_type(12'd5, 5'd0, 3'b000, 5'd1, op_imm), 5'd1, 64'd5);
    write_op(i_type(12'hffd, 5'd0, 3'b000, 5'd2, op_imm), 5'd2, 64'hffff_ffff_ffff_fffd);
    // register ops on 5 and -3
    write_op(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 64'd2);
    write_op(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 64'd8);
    write_op(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd5), 5'd5, 64'hffff_ffff_ffff_fff8);
    write_op(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 5'd6, 64'hffff_ffff_ffff_fffd);
    write_op(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd7), 5'd7, 64'd5);
    // six bit shift amounts
    write_op(i_type({6'd0, 6'd40}, 5'd1, 3'b001, 5'd8, op_imm), 5'd8, 64'h0000_0500_0000_0000);
    write_op(i_type({6'd0, 6'd60}, 5'd2, 3'b101, 5'd9, op_imm), 5'd9, 64'hf);
    // lui, second one sign extends
    write_op(u_type(20'h12345, 5'd10, op_lui), 5'd10, 64'h0000_0000_1234_5000);
    write_op(u_type(20'h80000, 5'd11, op_lui), 5'd11, 64'hffff_ffff_8000_0000);
    // addi x0 is dropped, then x0 + x1
    queue_strobe(i_type(12'd7, 5'd1, 3'b000, 5'd0, op_imm), 1'b0, 5'd0, 64'd0,
                 model_pc + 64'd4, 1'b0, 1'b0);
    write_op(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd12), 5'd12, 64'd5);
    write_op(u_type(20'h00001, 5'd13, op_auipc), 5'd13, model_pc + 64'h1000);
    // jal +16, link pc + 4
    queue_strobe(j_type(21'd16, 5'd14), 1'b1, 5'd14, model_pc + 64'd4,
                 model_pc + 64'd16, 1'b0, 1'b0);
    base = model_pc;
    write_op(u_type(20'h00000, 5'd15, op_auipc), 5'd15, base);
    // jalr to x15 + 13, bit 0 cleared
    queue_strobe(i_type(12'd13, 5'd15, 3'b000, 5'd16, op_jalr), 1'b1, 5'd16,
                 model_pc + 64'd4, (base + 64'd13) & ~64'd1, 1'b0, 1'b0);
    // stores then loads back
    queue_strobe(s_type(12'd24, 5'd11, 5'd0), 1'b0, 5'd0, 64'd0, model_pc + 64'd4, 1'b0, 1'b0);
    queue_strobe(s_type(12'd8, 5'd8, 5'd0), 1'b0, 5'd0, 64'd0, model_pc + 64'd4, 1'b0, 1'b0);
    write_op(i_type(12'd24, 5'd0, 3'b011, 5'd17, op_load), 5'd17, 64'hffff_ffff_8000_0000);
    write_op(i_type(12'd3, 5'd1, 3'b011, 5'd18, op_load), 5'd18, 64'h0000_0500_0000_0000);
    // mul and srai encodings are not supported
    queue_strobe(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd19), 1'b0, 5'd0, 64'd0,
                 model_pc + 64'd4, 1'b1, 1'b0);
    queue_strobe(i_type({6'b010000, 6'd1}, 5'd1, 3'b101, 5'd19, op_imm), 1'b0, 5'd0, 64'd0,
                 model_pc + 64'd4, 1'b1, 1'b0);
    // x19 never written
    write_op(r_type(7'h00, 5'd0, 5'd19, 3'b000, 5'd20), 5'd20, 64'd0);
    queue_strobe(32'h0010_0073, 1'b0, 5'd0, 64'd0, model_pc + 64'd4, 1'b0, 1'b1);
    // halted from here on
    write_op(i_type(12'd1, 5'd0, 3'b000, 5'd21, op_imm), 5'd21, 64'd1);
    queue_strobe(j_type(21'd8, 5'd22), 1'b1, 5'd22, 64'd0, model_pc + 64'd8, 1'b0, 1'b0);
  endtask

  task automatic check_field(string what, int step, logic [xlen-1:0] got,
                             logic [xlen-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %0d ns: step %0d %s is %h, expected %h", $time, step, what, got, exp);
    end
  endtask

  task automatic check_step(int i, step_t s);
    check_field("pc", i, pc, s.exp_pc);
    check_field("retire.valid", i, 64'(retire.valid), 64'(s.exp_valid));
    check_field("retire.wen", i, 64'(retire.wen), 64'(s.exp_wen));
    check_field("halted", i, 64'(halted), 64'(s.exp_halted));
    check_field("illegal", i, 64'(illegal), 64'(s.exp_illegal));
    if (s.exp_valid) begin
      check_field("retire.pc", i, retire.pc, s.exp_pc);
    end
    if (s.exp_wen) begin
      check_field("retire.rd", i, 64'(retire.rd), 64'(s.exp_rd));
      check_field("retire.wdata", i, retire.wdata, s.exp_wdata);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    inst_valid  = 1'b0;
    inst        = '0;
    table_ready = 1'b0;
    checks      = 0;
    errors      = 0;
    void'($urandom(16));
    build_program();
    table_ready = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    #1;
    // state straight out of reset
    check_field("reset pc", -1, pc, pc_reset);
    check_field("reset halted", -1, 64'(halted), 64'd0);
    check_field("reset illegal", -1, 64'(illegal), 64'd0);
    check_field("reset retire.valid", -1, 64'(retire.valid), 64'd0);
    for (int i = 0; i < steps.size(); i++) begin
      @(posedge clk);
      inst_valid <= steps[i].strobe;
      inst       <= steps[i].word;
      // sample mid cycle, after the combinational settle
      #1;
      check_step(i, steps[i]);
    end
    @(posedge clk);
    inst_valid <= 1'b0;
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // bound of 8 cycles per row plus reset
  initial begin
    longint limit_ns;
    wait (table_ready);
    limit_ns = (longint'(steps.size()) * 8 + 5) * 4;
    #(limit_ns);
    $display("timeout: run did not finish within %0d ns", limit_ns);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_data_mem.sv
logic/rv_pc_unit.sv
logic/rv_core.sv
tests/rv_core_tb.sv

/* Makefile */
# Verilator build for the rv64i core testbench

SIM       = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = rv_core_tb
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "run passed" || \
		(echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
